// File: hw/apb_periph_pkg.sv
/* APB peripheral subsystem definitions */

package apb_periph_pkg;

   localparam int unsigned APB_AW = 32;
   localparam int unsigned APB_DW = 32;

   // Master side of the bus
   typedef struct packed {
      logic [APB_AW-1:0] paddr;
      logic [APB_DW-1:0] pwdata;
      logic              pwrite;
      logic              psel;
      logic              penable;
   } apb_req_t;

   // Slave answer
   typedef struct packed {
      logic [APB_DW-1:0] prdata;
      logic              pready;
      logic              pslverr;
   } apb_rsp_t;

   // Last-level cache configuration
   typedef struct packed {
      logic [31:0] cache_addr_start;
      logic [31:0] cache_addr_end;
      logic [31:0] spm_addr_start;
   } llc_cfg_t;

   // One-cycle cache event strobes
   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } llc_event_t;

   typedef struct packed {
      logic rstn;
      logic en_sa_boot;
      logic fetch_en;
   } cluster_ctrl_t;

   // Region codes matched against paddr[15:12]
   localparam logic [3:0] REGION_GPIO    = 4'd0;
   localparam logic [3:0] REGION_SOCCTRL = 4'd1;
   localparam logic [3:0] REGION_PWM     = 4'd2;

   // Word offsets in paddr[5:2]
   localparam logic [3:0] GPIO_DIR = 4'd0;
   localparam logic [3:0] GPIO_OUT = 4'd1;
   localparam logic [3:0] GPIO_IN  = 4'd2;

   localparam logic [3:0] SOC_CLUSTER     = 4'd0;
   localparam logic [3:0] SOC_CACHE_START = 4'd1;
   localparam logic [3:0] SOC_CACHE_END   = 4'd2;
   localparam logic [3:0] SOC_SPM_START   = 4'd3;
   localparam logic [3:0] SOC_RD_HIT      = 4'd4;
   localparam logic [3:0] SOC_RD_MISS     = 4'd5;
   localparam logic [3:0] SOC_WR_HIT      = 4'd6;
   localparam logic [3:0] SOC_WR_MISS     = 4'd7;

   localparam logic [3:0] PWM_CTRL   = 4'd0;
   localparam logic [3:0] PWM_PERIOD = 4'd1;
   // Four compare registers follow from here
   localparam logic [3:0] PWM_CMP0   = 4'd2;

endpackage

// File: hw/periph_bus_decoder.sv
/* Peripheral bus decoder */

`timescale 1ns/1ns

module periph_bus_decoder
   import apb_periph_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,

   input  apb_req_t req_i,
   output apb_rsp_t rsp_o,

   output apb_req_t gpio_req_o,
   output apb_req_t soc_req_o,
   output apb_req_t pwm_req_o,

   input  apb_rsp_t gpio_rsp_i,
   input  apb_rsp_t soc_rsp_i,
   input  apb_rsp_t pwm_rsp_i
);

   logic [3:0] region;
   logic       access;

   assign region = req_i.paddr[15:12];
   assign access = req_i.psel & req_i.penable;

   // Psel goes only to the addressed peer
   always_comb begin
      gpio_req_o      = req_i;
      soc_req_o       = req_i;
      pwm_req_o       = req_i;
      gpio_req_o.psel = req_i.psel && (region == REGION_GPIO);
      soc_req_o.psel  = req_i.psel && (region == REGION_SOCCTRL);
      pwm_req_o.psel  = req_i.psel && (region == REGION_PWM);
   end

   always_comb begin
      case (region)
         REGION_GPIO: begin
            rsp_o = gpio_rsp_i;
         end
         REGION_SOCCTRL: begin
            rsp_o = soc_rsp_i;
         end
         REGION_PWM: begin
            rsp_o = pwm_rsp_i;
         end
         default: begin
            // Nothing mapped here
            rsp_o.prdata  = '0;
            rsp_o.pready  = access;
            rsp_o.pslverr = access;
         end
      endcase
   end

   a_one_peer: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({gpio_req_o.psel, soc_req_o.psel, pwm_req_o.psel})
   ) else $error("more than one peer selected");

endmodule

// File: hw/apb_gpio.sv
/* GPIO register block */

`timescale 1ns/1ns

module apb_gpio
   import apb_periph_pkg::*;
#(
   parameter int unsigned NUM_GPIO = 32
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  apb_req_t            req_i,
   output apb_rsp_t            rsp_o,

   input  logic [NUM_GPIO-1:0] gpio_in_i,
   output logic [NUM_GPIO-1:0] gpio_out_o,
   output logic [NUM_GPIO-1:0] gpio_oe_o
);

   logic [NUM_GPIO-1:0] dir_q;
   logic [NUM_GPIO-1:0] out_q;
   logic [NUM_GPIO-1:0] sync_q1;
   logic [NUM_GPIO-1:0] sync_q2;
   logic [3:0]          offset;
   logic                wr_en;

   assign offset = req_i.paddr[5:2];
   assign wr_en  = req_i.psel & req_i.penable & req_i.pwrite;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dir_q <= '0;
         out_q <= '0;
      end else if (wr_en) begin
         // GPIO_IN is read only
         case (offset)
            GPIO_DIR: dir_q <= req_i.pwdata[NUM_GPIO-1:0];
            GPIO_OUT: out_q <= req_i.pwdata[NUM_GPIO-1:0];
            default: ;
         endcase
      end
   end

   // Two-stage pad synchronizer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= gpio_in_i;
         sync_q2 <= sync_q1;
      end
   end

   always_comb begin
      case (offset)
         GPIO_DIR: rsp_o.prdata = APB_DW'(dir_q);
         GPIO_OUT: rsp_o.prdata = APB_DW'(out_q);
         GPIO_IN:  rsp_o.prdata = APB_DW'(sync_q2);
         default:  rsp_o.prdata = '0;
      endcase
   end

   // Zero wait states
   assign rsp_o.pready  = req_i.psel & req_i.penable;
   assign rsp_o.pslverr = 1'b0;

   assign gpio_oe_o  = dir_q;
   assign gpio_out_o = out_q & dir_q;

   a_out_needs_oe: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (gpio_out_o & ~gpio_oe_o) == '0
   ) else $error("gpio driven high on an input pin");

endmodule

// File: hw/soc_control.sv
/* SoC control and cache event counters */

`timescale 1ns/1ns

module soc_control
   import apb_periph_pkg::*;
(
   input  logic          clk_i,
   input  logic          rst_n_i,

   input  apb_req_t      req_i,
   output apb_rsp_t      rsp_o,

   input  llc_event_t    llc_event_i,
   output cluster_ctrl_t cluster_o,
   output llc_cfg_t      llc_cfg_o
);

   cluster_ctrl_t cluster_q;
   llc_cfg_t      cfg_q;
   logic [31:0]   cnt_q [4];
   logic [3:0]    evt;
   logic [3:0]    clr;
   logic [3:0]    offset;
   logic          wr_en;

   assign offset = req_i.paddr[5:2];
   assign wr_en  = req_i.psel & req_i.penable & req_i.pwrite;

   // Counter order follows the offsets 4 to 7
   assign evt = {llc_event_i.write_miss, llc_event_i.write_hit,
                 llc_event_i.read_miss, llc_event_i.read_hit};

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         clr[i] = wr_en && (offset == SOC_RD_HIT + 4'(i));
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cluster_q <= '0;
         cfg_q     <= '0;
      end else if (wr_en) begin
         case (offset)
            SOC_CLUSTER: begin
               cluster_q.rstn       <= req_i.pwdata[0];
               cluster_q.en_sa_boot <= req_i.pwdata[1];
               cluster_q.fetch_en   <= req_i.pwdata[2];
            end
            SOC_CACHE_START: cfg_q.cache_addr_start <= req_i.pwdata;
            SOC_CACHE_END:   cfg_q.cache_addr_end   <= req_i.pwdata;
            SOC_SPM_START:   cfg_q.spm_addr_start   <= req_i.pwdata;
            default: ;
         endcase
      end
   end

   // Saturating event counters; a clear wins over an event
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 4; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (clr[i]) begin
               cnt_q[i] <= '0;
            end else if (evt[i] && (cnt_q[i] != '1)) begin
               cnt_q[i] <= cnt_q[i] + 32'd1;
            end
         end
      end
   end

   always_comb begin
      case (offset)
         SOC_CLUSTER: begin
            rsp_o.prdata = APB_DW'({cluster_q.fetch_en, cluster_q.en_sa_boot,
                                    cluster_q.rstn});
         end
         SOC_CACHE_START: rsp_o.prdata = cfg_q.cache_addr_start;
         SOC_CACHE_END:   rsp_o.prdata = cfg_q.cache_addr_end;
         SOC_SPM_START:   rsp_o.prdata = cfg_q.spm_addr_start;
         SOC_RD_HIT:      rsp_o.prdata = cnt_q[0];
         SOC_RD_MISS:     rsp_o.prdata = cnt_q[1];
         SOC_WR_HIT:      rsp_o.prdata = cnt_q[2];
         SOC_WR_MISS:     rsp_o.prdata = cnt_q[3];
         default:         rsp_o.prdata = '0;
      endcase
   end

   assign rsp_o.pready  = req_i.psel & req_i.penable;
   assign rsp_o.pslverr = 1'b0;

   assign cluster_o = cluster_q;
   assign llc_cfg_o = cfg_q;

   for (genvar g = 0; g < 4; g++) begin : gen_cnt_chk
      a_cnt_stable: assert property (
         @(posedge clk_i) disable iff (!rst_n_i)
         (!evt[g] && !clr[g]) |=> $stable(cnt_q[g])
      ) else $error("event counter %0d moved without cause", g);
   end

endmodule

// File: hw/pwm_timer.sv
/* Four channel PWM timer */

`timescale 1ns/1ns

module pwm_timer
   import apb_periph_pkg::*;
#(
   parameter int unsigned PWM_CNT_W = 16
) (
   input  logic       clk_i,
   input  logic       rst_n_i,

   input  apb_req_t   req_i,
   output apb_rsp_t   rsp_o,

   output logic [3:0] pwm_o
);

   logic                 en_q;
   logic [PWM_CNT_W-1:0] period_q;
   logic [PWM_CNT_W-1:0] cmp_q [4];
   logic [PWM_CNT_W-1:0] cnt_q;
   logic [3:0]           offset;
   logic [3:0]           cmp_idx;
   logic                 wr_en;
   logic                 is_cmp;

   assign offset  = req_i.paddr[5:2];
   assign cmp_idx = offset - PWM_CMP0;
   assign is_cmp  = (offset >= PWM_CMP0) && (offset <= PWM_CMP0 + 4'd3);
   assign wr_en   = req_i.psel & req_i.penable & req_i.pwrite;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         en_q     <= 1'b0;
         period_q <= '0;
         for (int i = 0; i < 4; i++) begin
            cmp_q[i] <= '0;
         end
      end else if (wr_en) begin
         if (offset == PWM_CTRL) begin
            en_q <= req_i.pwdata[0];
         end else if (offset == PWM_PERIOD) begin
            period_q <= req_i.pwdata[PWM_CNT_W-1:0];
         end else if (is_cmp) begin
            cmp_q[cmp_idx[1:0]] <= req_i.pwdata[PWM_CNT_W-1:0];
         end
      end
   end

   // Restarts on a period write so it never runs past a shrunk period
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (!en_q || (wr_en && offset == PWM_PERIOD)) begin
         cnt_q <= '0;
      end else if (cnt_q >= period_q) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   always_comb begin
      for (int n = 0; n < 4; n++) begin
         pwm_o[n] = en_q && (cnt_q < cmp_q[n]);
      end
   end

   always_comb begin
      if (offset == PWM_CTRL) begin
         rsp_o.prdata = APB_DW'(en_q);
      end else if (offset == PWM_PERIOD) begin
         rsp_o.prdata = APB_DW'(period_q);
      end else if (is_cmp) begin
         rsp_o.prdata = APB_DW'(cmp_q[cmp_idx[1:0]]);
      end else begin
         rsp_o.prdata = '0;
      end
   end

   assign rsp_o.pready  = req_i.psel & req_i.penable;
   assign rsp_o.pslverr = 1'b0;

   a_cnt_in_period: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      en_q |-> (cnt_q <= period_q)
   ) else $error("pwm counter beyond period");

endmodule

// File: hw/apb_subsystem.sv
/* APB peripheral subsystem top */

`timescale 1ns/1ns

module apb_subsystem
   import apb_periph_pkg::*;
#(
   parameter int unsigned NUM_GPIO  = 32,
   parameter int unsigned PWM_CNT_W = 16
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  apb_req_t            apb_req_i,
   output apb_rsp_t            apb_rsp_o,

   input  logic [NUM_GPIO-1:0] gpio_in_i,
   output logic [NUM_GPIO-1:0] gpio_out_o,
   output logic [NUM_GPIO-1:0] gpio_oe_o,

   input  llc_event_t          llc_event_i,
   output cluster_ctrl_t       cluster_o,
   output llc_cfg_t            llc_cfg_o,

   output logic [3:0]          pwm_o
);

   apb_req_t gpio_req, soc_req, pwm_req;
   apb_rsp_t gpio_rsp, soc_rsp, pwm_rsp;

   periph_bus_decoder i_periph_bus_decoder (
      .clk_i      ( clk_i     ),
      .rst_n_i    ( rst_n_i   ),
      .req_i      ( apb_req_i ),
      .rsp_o      ( apb_rsp_o ),
      .gpio_req_o ( gpio_req  ),
      .soc_req_o  ( soc_req   ),
      .pwm_req_o  ( pwm_req   ),
      .gpio_rsp_i ( gpio_rsp  ),
      .soc_rsp_i  ( soc_rsp   ),
      .pwm_rsp_i  ( pwm_rsp   )
   );

   apb_gpio #(
      .NUM_GPIO ( NUM_GPIO )
   ) i_apb_gpio (
      .clk_i      ( clk_i      ),
      .rst_n_i    ( rst_n_i    ),
      .req_i      ( gpio_req   ),
      .rsp_o      ( gpio_rsp   ),
      .gpio_in_i  ( gpio_in_i  ),
      .gpio_out_o ( gpio_out_o ),
      .gpio_oe_o  ( gpio_oe_o  )
   );

   soc_control i_soc_control (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .req_i       ( soc_req     ),
      .rsp_o       ( soc_rsp     ),
      .llc_event_i ( llc_event_i ),
      .cluster_o   ( cluster_o   ),
      .llc_cfg_o   ( llc_cfg_o   )
   );

   pwm_timer #(
      .PWM_CNT_W ( PWM_CNT_W )
   ) i_pwm_timer (
      .clk_i   ( clk_i   ),
      .rst_n_i ( rst_n_i ),
      .req_i   ( pwm_req ),
      .rsp_o   ( pwm_rsp ),
      .pwm_o   ( pwm_o   )
   );

endmodule

// File: include/tb_apb_tasks.svh
/* APB access tasks and test bookkeeping */

`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

localparam int PREADY_TIMEOUT = 16;

int err_cnt   = 0;
int err_mark  = 0;
int tests_run = 0;
int tests_bad = 0;

function automatic logic [31:0] reg_addr(input logic [3:0] region, input logic [3:0] offset);
   return {16'h0000, region, 6'h00, offset, 2'b00};
endfunction

// Setup cycle then access cycles until pready
task automatic run_transfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
   int   waited;
   logic done;
   waited = 0;
   done   = 1'b0;
   rdata  = '0;
   err    = 1'b0;
   @(posedge clk_i);
   apb_req.paddr   <= addr;
   apb_req.pwdata  <= wdata;
   apb_req.pwrite  <= wr;
   apb_req.psel    <= 1'b1;
   apb_req.penable <= 1'b0;
   @(posedge clk_i);
   apb_req.penable <= 1'b1;
   while (!done && waited < PREADY_TIMEOUT) begin
      @(negedge clk_i);
      if (apb_rsp.pready) begin
         rdata = apb_rsp.prdata;
         err   = apb_rsp.pslverr;
         done  = 1'b1;
      end
      waited++;
      @(posedge clk_i);
   end
   apb_req.psel    <= 1'b0;
   apb_req.penable <= 1'b0;
   if (!done) begin
      err_cnt++;
      $display("Timeout at %0t: no pready for address 0x%08h", $time, addr);
   end
endtask

task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
   logic [31:0] unused_rdata;
   logic        unused_err;
   run_transfer(addr, 1'b1, data, unused_rdata, unused_err);
endtask

task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
   logic unused_err;
   run_transfer(addr, 1'b0, 32'h0, data, unused_err);
endtask

task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
   assert (got === exp) else begin
      err_cnt++;
      $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
   end
endtask

task automatic finish_test(input string name);
   tests_run++;
   if (err_cnt == err_mark) begin
      $display("[%0t] %s: ok", $time, name);
   end else begin
      tests_bad++;
      $display("[%0t] %s: %0d error(s)", $time, name, err_cnt - err_mark);
   end
   err_mark = err_cnt;
endtask

`endif

// File: testbench/tb_apb_subsystem.sv
/* APB subsystem testbench */

`timescale 1ns/1ns

module tb_apb_subsystem
   import apb_periph_pkg::*;
();

   logic          clk_i;
   logic          rst_n_i;
   apb_req_t      apb_req;
   apb_rsp_t      apb_rsp;
   logic [31:0]   gpio_in;
   logic [31:0]   gpio_out;
   logic [31:0]   gpio_oe;
   llc_event_t    llc_event;
   cluster_ctrl_t cluster;
   llc_cfg_t      llc_cfg;
   logic [3:0]    pwm;

   `include "tb_apb_tasks.svh"

   apb_subsystem #(
      .NUM_GPIO  ( 32 ),
      .PWM_CNT_W ( 16 )
   ) dut (
      .clk_i       ( clk_i     ),
      .rst_n_i     ( rst_n_i   ),
      .apb_req_i   ( apb_req   ),
      .apb_rsp_o   ( apb_rsp   ),
      .gpio_in_i   ( gpio_in   ),
      .gpio_out_o  ( gpio_out  ),
      .gpio_oe_o   ( gpio_oe   ),
      .llc_event_i ( llc_event ),
      .cluster_o   ( cluster   ),
      .llc_cfg_o   ( llc_cfg   ),
      .pwm_o       ( pwm       )
   );

   always #4 clk_i = ~clk_i;

   // Zero wait states, so completion lands one cycle after setup
   a_two_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(apb_req.psel) |-> !apb_req.penable ##1 (apb_req.penable && apb_rsp.pready))
   else begin
      err_cnt++;
      $display("ERR %0t: transfer did not complete two cycles after psel rose", $time);
   end

   a_slverr_map: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (apb_req.psel && apb_req.penable) |->
      (apb_rsp.pslverr == (apb_req.paddr[15:12] > REGION_PWM)))
   else begin
      err_cnt++;
      $display("ERR %0t: pslverr disagrees with the address map", $time);
   end

   a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !apb_req.psel |-> !(apb_rsp.pready || apb_rsp.pslverr))
   else begin
      err_cnt++;
      $display("ERR %0t: pready or pslverr high while the bus is idle", $time);
   end

   initial begin
      logic [31:0] rdata;
      logic [31:0] v_dir;
      logic [31:0] v_out;
      logic [31:0] v_in;
      logic [31:0] v_cl;
      logic [31:0] v_cache [3];
      logic        err;
      int          n_evt [4];
      int          high [4];
      int          cmp [4];
      int          period;
      logic [3:0]  region;
      logic [166:0] snap;
      clk_i     = 1'b0;
      rst_n_i   = 1'b0;
      apb_req   = '0;
      gpio_in   = '0;
      llc_event = '0;
      void'($urandom(32'h6b50));
      repeat (8) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);

      expect_eq(gpio_oe, '0, "gpio_oe_o");
      expect_eq(gpio_out, '0, "gpio_out_o");
      expect_eq({25'd0, cluster, pwm}, '0, "cluster and pwm outputs");
      expect_eq(llc_cfg[95:64] | llc_cfg[63:32] | llc_cfg[31:0], '0, "llc_cfg_o");
      for (int g = 0; g < 3; g++) begin
         for (int r = 0; r < 16; r++) begin
            read_reg(reg_addr(4'(g), 4'(r)), rdata);
            expect_eq(rdata, '0, $sformatf("reset value region %0d offset %0d", g, r));
         end
      end
      finish_test("reset state");

      v_dir = $urandom;
      v_out = $urandom;
      v_in  = $urandom;
      write_reg(reg_addr(REGION_GPIO, GPIO_DIR), v_dir);
      write_reg(reg_addr(REGION_GPIO, GPIO_OUT), v_out);
      @(negedge clk_i);
      expect_eq(gpio_oe, v_dir, "gpio_oe_o");
      expect_eq(gpio_out, v_out & v_dir, "gpio_out_o");
      @(posedge clk_i);
      gpio_in <= v_in;
      repeat (2) @(posedge clk_i);
      read_reg(reg_addr(REGION_GPIO, GPIO_IN), rdata);
      expect_eq(rdata, v_in, "GPIO_IN readback");
      finish_test("gpio");

      v_cl = $urandom;
      for (int i = 0; i < 3; i++) begin
         v_cache[i] = $urandom;
         write_reg(reg_addr(REGION_SOCCTRL, SOC_CACHE_START + 4'(i)), v_cache[i]);
      end
      write_reg(reg_addr(REGION_SOCCTRL, SOC_CLUSTER), v_cl);
      @(negedge clk_i);
      expect_eq(llc_cfg.cache_addr_start, v_cache[0], "cache_addr_start");
      expect_eq(llc_cfg.cache_addr_end, v_cache[1], "cache_addr_end");
      expect_eq(llc_cfg.spm_addr_start, v_cache[2], "spm_addr_start");
      expect_eq({29'd0, cluster}, {29'd0, v_cl[0], v_cl[1], v_cl[2]}, "cluster_o");
      read_reg(reg_addr(REGION_SOCCTRL, SOC_CLUSTER), rdata);
      expect_eq(rdata, {29'd0, v_cl[2:0]}, "SOC_CLUSTER readback");
      for (int i = 0; i < 3; i++) begin
         read_reg(reg_addr(REGION_SOCCTRL, SOC_CACHE_START + 4'(i)), rdata);
         expect_eq(rdata, v_cache[i], $sformatf("cache register %0d readback", i));
      end
      finish_test("cluster and cache registers");

      for (int i = 0; i < 4; i++) begin
         n_evt[i] = $urandom_range(50, 0);
      end
      // Counter order read_hit, read_miss, write_hit, write_miss
      for (int c = 0; c < 50; c++) begin
         @(posedge clk_i);
         llc_event <= {(c < n_evt[0]), (c < n_evt[1]), (c < n_evt[2]), (c < n_evt[3])};
      end
      @(posedge clk_i);
      llc_event <= '0;
      for (int i = 0; i < 4; i++) begin
         read_reg(reg_addr(REGION_SOCCTRL, SOC_RD_HIT + 4'(i)), rdata);
         expect_eq(rdata, n_evt[i], $sformatf("event counter %0d", i));
         write_reg(reg_addr(REGION_SOCCTRL, SOC_RD_HIT + 4'(i)), $urandom);
         read_reg(reg_addr(REGION_SOCCTRL, SOC_RD_HIT + 4'(i)), rdata);
         expect_eq(rdata, '0, $sformatf("event counter %0d after clear", i));
      end
      finish_test("cache event counters");

      period = $urandom_range(63, 0);
      write_reg(reg_addr(REGION_PWM, PWM_PERIOD), period);
      for (int n = 0; n < 4; n++) begin
         cmp[n]  = $urandom_range(70, 0);
         high[n] = 0;
         write_reg(reg_addr(REGION_PWM, PWM_CMP0 + 4'(n)), cmp[n]);
      end
      write_reg(reg_addr(REGION_PWM, PWM_CTRL), 32'd1);
      for (int k = 0; k < 4 * (period + 1); k++) begin
         @(negedge clk_i);
         for (int n = 0; n < 4; n++) begin
            high[n] += int'(pwm[n]);
         end
      end
      for (int n = 0; n < 4; n++) begin
         expect_eq(high[n], 4 * ((cmp[n] < period + 1) ? cmp[n] : period + 1),
                   $sformatf("pwm channel %0d high cycles", n));
      end
      write_reg(reg_addr(REGION_PWM, PWM_CTRL), 32'd0);
      for (int k = 0; k < 2 * (period + 1); k++) begin
         @(negedge clk_i);
         expect_eq({28'd0, pwm}, '0, "pwm_o while disabled");
      end
      finish_test("pwm duty");

      snap   = {gpio_oe, gpio_out, cluster, llc_cfg, pwm};
      region = 4'($urandom_range(15, 3));
      run_transfer(reg_addr(region, 4'($urandom)), 1'b1, $urandom, rdata, err);
      expect_eq({31'd0, err}, 32'd1, "pslverr on unmapped write");
      run_transfer(reg_addr(region, 4'($urandom)), 1'b0, 32'h0, rdata, err);
      expect_eq({31'd0, err}, 32'd1, "pslverr on unmapped read");
      expect_eq(rdata, '0, "prdata on unmapped read");
      @(negedge clk_i);
      expect_eq(32'({gpio_oe, gpio_out, cluster, llc_cfg, pwm} != snap), '0,
                "outputs changed by unmapped transfer");
      finish_test("unmapped address");

      $display("Tests run: %0d, with errors: %0d, total errors: %0d",
               tests_run, tests_bad, err_cnt);
      if (err_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+include
hw/apb_periph_pkg.sv
hw/periph_bus_decoder.sv
hw/apb_gpio.sv
hw/soc_control.sv
hw/pwm_timer.sv
hw/apb_subsystem.sv
testbench/tb_apb_subsystem.sv

// File: run.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_apb_subsystem \
   -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
# A simulator abort without the testbench report also counts as a failure
(./obj_dir/sim_tb || echo "Testbench failed") > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
